// ==== logic/frame_match_pkg.sv ====
// shared widths, flag bit positions and lfsr constants; the store depth fixes pat_addr_t at 11 bits.
`default_nettype none

package frame_match_pkg;

	localparam int num_slots = 4;
	localparam int pattern_depth = 2048;
	localparam int ext_max = 16;

	// bit positions inside each slot's flag byte.
	localparam int flag_any = 0;
	localparam int flag_last = 1;
	localparam int flag_repl = 2;
	localparam int flag_rand = 3;
	localparam int flag_capture = 4;

	// fibonacci taps 8, 6, 5 and 4 as a mask over bits 7..0.
	localparam logic [7:0] lfsr_seed = 8'd11;
	localparam logic [7:0] lfsr_taps = 8'b1011_1000;

	typedef logic [7:0] byte_t;
	typedef logic [10:0] pat_addr_t;
	typedef logic [3:0] slot_mask_t;

	// slot i sits in byte i.
	typedef logic [31:0] pat_word_t;

	// counts 0 to ext_max, so one bit wider than the index.
	typedef logic [4:0] ext_num_t;

	// capture k sits in byte k.
	typedef logic [127:0] ext_data_t;

	typedef logic [1:0] report_id_t;

endpackage

`default_nettype wire

// ==== logic/frame_result_if.sv ====
// per-frame result from tracker to report; the fields are only valid while frame_end is high.
`timescale 1ns/1ns
`default_nettype none

interface frame_result_if import frame_match_pkg::*; ();

	logic frame_end;
	slot_mask_t slot_match;
	ext_num_t ext_num;
	ext_data_t ext_data;

	modport src (output frame_end, output slot_match, output ext_num, output ext_data);

	modport dst (input frame_end, input slot_match, input ext_num, input ext_data);

endinterface

`default_nettype wire

// ==== logic/byte_lfsr.sv ====
// 8-bit fibonacci lfsr; steps once per cycle with step high, so its sequence follows valid beats only.
`timescale 1ns/1ns
`default_nettype none

module byte_lfsr import frame_match_pkg::*; (
	input wire logic s_axis_clk,
	input wire logic rst_n_cdc,
	input wire logic step,
	output byte_t value
);

	logic feedback;

	// xor of the tapped bits enters at bit 0.
	assign feedback = ^(value & lfsr_taps);

	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc) begin
			value <= lfsr_seed;
		end else if (step) begin
			value <= {value[6:0], feedback};
		end
	end

endmodule

`default_nettype wire

// ==== logic/pattern_store.sv ====
// pattern RAM with one write and one synchronous read port; contents survive reset and start unknown.
`timescale 1ns/1ns
`default_nettype none

module pattern_store import frame_match_pkg::*; (
	input wire logic s_axis_clk,
	input wire logic cfg_we,
	input pat_addr_t cfg_addr,
	input pat_word_t cfg_data,
	input pat_word_t cfg_flags,
	input pat_addr_t pat_addr,
	output pat_word_t pat_data,
	output pat_word_t pat_flags
);

	pat_word_t data_mem [pattern_depth];
	pat_word_t flag_mem [pattern_depth];

	always_ff @(posedge s_axis_clk) begin
		if (cfg_we) begin
			data_mem[cfg_addr] <= cfg_data;
			flag_mem[cfg_addr] <= cfg_flags;
		end
	end

	// read data follows the address by one cycle.
	always_ff @(posedge s_axis_clk) begin
		pat_data <= data_mem[pat_addr];
		pat_flags <= flag_mem[pat_addr];
	end

endmodule

`default_nettype wire

// ==== logic/pattern_tracker.sv ====
// compares one byte per beat against four slots; no back-pressure, positions past 2047 are not compared.
`timescale 1ns/1ns
`default_nettype none

module pattern_tracker import frame_match_pkg::*; (
	input wire logic s_axis_clk,
	input wire logic rst_n_cdc,
	input byte_t s_axis_tdata,
	input wire logic s_axis_tuser,
	input wire logic s_axis_tlast,
	input wire logic s_axis_tvalid,
	output byte_t m_axis_tdata,
	output logic m_axis_tuser,
	output logic m_axis_tlast,
	output logic m_axis_tvalid,
	output pat_addr_t pat_addr,
	input pat_word_t pat_data,
	input pat_word_t pat_flags,
	input byte_t rand_byte,
	frame_result_if.src res
);

	byte_t data_q;
	logic user_q;
	logic last_q;
	logic valid_q;
	logic addr_done;
	logic over_q;
	logic cmp_en;
	logic capture;
	slot_mask_t match_q;
	slot_mask_t match_base;
	slot_mask_t slot_fail;
	slot_mask_t repl_req;
	byte_t repl_data [num_slots];
	ext_num_t ext_base;
	ext_num_t ext_num_q;
	ext_data_t ext_data_q;

	always_ff @(posedge s_axis_clk) begin
		data_q <= s_axis_tdata;
		user_q <= s_axis_tuser;
		last_q <= s_axis_tlast;
		over_q <= addr_done;
	end

	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc) begin
			valid_q <= 1'b0;
			res.frame_end <= 1'b0;
		end else begin
			valid_q <= s_axis_tvalid;
			res.frame_end <= valid_q & last_q;
		end
	end

	// store read is issued here, so pat_data lines up with data_q.
	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc || s_axis_tlast) begin
			pat_addr <= '0;
			addr_done <= 1'b0;
		end else if (s_axis_tvalid) begin
			if (pat_addr != pat_addr_t'(pattern_depth - 1)) begin
				pat_addr <= pat_addr + pat_addr_t'(1);
			end else begin
				addr_done <= 1'b1;
			end
		end
	end

	assign cmp_en = valid_q & ~over_q;

	// the first beat of a back-to-back frame starts from a fresh match set.
	assign match_base = res.frame_end ? '1 : match_q;
	assign ext_base = res.frame_end ? '0 : ext_num_q;

	always_comb begin
		capture = 1'b0;
		for (int i = 0; i < num_slots; i++) begin
			slot_fail[i] = 1'b0;
			repl_req[i] = 1'b0;
			repl_data[i] = '0;
			if (cmp_en) begin
				if (pat_data[8*i +: 8] != data_q && !pat_flags[8*i + flag_any]) begin
					slot_fail[i] = 1'b1;
				end
				if (pat_flags[8*i + flag_last] && !last_q) begin
					slot_fail[i] = 1'b1;
				end
				// capture does not care whether the slot still matches.
				if (pat_flags[8*i + flag_capture]) begin
					capture = 1'b1;
				end
				if (match_base[i]) begin
					if (pat_flags[8*i + flag_repl]) begin
						repl_req[i] = 1'b1;
						repl_data[i] = pat_data[8*i +: 8];
					end else if (pat_flags[8*i + flag_rand]) begin
						repl_req[i] = 1'b1;
						repl_data[i] = rand_byte;
					end
				end
			end
		end
	end

	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc) begin
			match_q <= '1;
		end else begin
			match_q <= match_base & ~slot_fail;
		end
	end

	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc) begin
			ext_num_q <= '0;
			ext_data_q <= '0;
		end else begin
			if (res.frame_end) begin
				ext_data_q <= '0;
			end
			ext_num_q <= ext_base;
			if (capture && ext_base != ext_num_t'(ext_max)) begin
				ext_data_q[8*ext_base[3:0] +: 8] <= data_q;
				ext_num_q <= ext_base + ext_num_t'(1);
			end
		end
	end

	// lowest slot wins, so walk down from the top.
	always_comb begin
		m_axis_tdata = data_q;
		for (int i = num_slots - 1; i >= 0; i--) begin
			if (repl_req[i]) begin
				m_axis_tdata = repl_data[i];
			end
		end
	end

	assign m_axis_tuser = user_q;
	assign m_axis_tlast = last_q;
	assign m_axis_tvalid = valid_q;

	assign res.slot_match = match_q;
	assign res.ext_num = ext_num_q;
	assign res.ext_data = ext_data_q;

endmodule

`default_nettype wire

// ==== logic/match_report.sv ====
// holds the last nonzero masked result; the report number wraps after 3 and the first report is 1.
`timescale 1ns/1ns
`default_nettype none

module match_report import frame_match_pkg::*; (
	input wire logic s_axis_clk,
	input wire logic rst_n_cdc,
	input slot_mask_t match_en,
	frame_result_if.dst res,
	output slot_mask_t match,
	output report_id_t match_id,
	output ext_num_t match_ext_num,
	output ext_data_t match_ext_data
);

	slot_mask_t masked;
	slot_mask_t pend_match;
	logic pend_valid;
	ext_num_t pend_num;
	ext_data_t pend_data;

	assign masked = res.slot_match & match_en;

	// one staging cycle puts the report three edges behind the last beat.
	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc) begin
			pend_valid <= 1'b0;
		end else begin
			pend_valid <= res.frame_end && masked != '0;
		end
	end

	always_ff @(posedge s_axis_clk) begin
		if (res.frame_end) begin
			pend_match <= masked;
			pend_num <= res.ext_num;
			pend_data <= res.ext_data;
		end
	end

	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc) begin
			match <= '0;
			match_id <= '0;
			match_ext_num <= '0;
			match_ext_data <= '0;
		end else if (pend_valid) begin
			match <= pend_match;
			match_id <= match_id + report_id_t'(1);
			match_ext_num <= pend_num;
			match_ext_data <= pend_data;
		end
	end

endmodule

`default_nettype wire

// ==== logic/frame_match_top.sv ====
// single clock, no back-pressure; load patterns through cfg_* only while the stream is idle.
`timescale 1ns/1ns
`default_nettype none

module frame_match_top import frame_match_pkg::*; (
	input wire logic s_axis_clk,
	input wire logic rst_n_cdc,
	input slot_mask_t match_en,
	output slot_mask_t match,
	output report_id_t match_id,
	output ext_num_t match_ext_num,
	output ext_data_t match_ext_data,
	input byte_t s_axis_tdata,
	input wire logic s_axis_tuser,
	input wire logic s_axis_tlast,
	input wire logic s_axis_tvalid,
	output byte_t m_axis_tdata,
	output logic m_axis_tuser,
	output logic m_axis_tlast,
	output logic m_axis_tvalid,
	input wire logic cfg_we,
	input pat_addr_t cfg_addr,
	input pat_word_t cfg_data,
	input pat_word_t cfg_flags
);

	pat_addr_t pat_addr;
	pat_word_t pat_data;
	pat_word_t pat_flags;
	byte_t rand_byte;

	frame_result_if res_if ();

	pattern_store u_store (
		.s_axis_clk(s_axis_clk),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_data(cfg_data),
		.cfg_flags(cfg_flags),
		.pat_addr(pat_addr),
		.pat_data(pat_data),
		.pat_flags(pat_flags)
	);

	// steps on the input beat, so its value is current when that beat is compared.
	byte_lfsr u_lfsr (
		.s_axis_clk(s_axis_clk),
		.rst_n_cdc(rst_n_cdc),
		.step(s_axis_tvalid),
		.value(rand_byte)
	);

	pattern_tracker u_tracker (
		.s_axis_clk(s_axis_clk),
		.rst_n_cdc(rst_n_cdc),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tuser(s_axis_tuser),
		.s_axis_tlast(s_axis_tlast),
		.s_axis_tvalid(s_axis_tvalid),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tuser(m_axis_tuser),
		.m_axis_tlast(m_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid),
		.pat_addr(pat_addr),
		.pat_data(pat_data),
		.pat_flags(pat_flags),
		.rand_byte(rand_byte),
		.res(res_if.src)
	);

	match_report u_report (
		.s_axis_clk(s_axis_clk),
		.rst_n_cdc(rst_n_cdc),
		.match_en(match_en),
		.res(res_if.dst),
		.match(match),
		.match_id(match_id),
		.match_ext_num(match_ext_num),
		.match_ext_data(match_ext_data)
	);

endmodule

`default_nettype wire

// ==== tests/frame_match_chk.sv ====
// protocol assertions bound into match_report; the failure counters are read by the testbench.
`timescale 1ns/1ns
`default_nettype none

module frame_match_chk import frame_match_pkg::*; (
	input wire logic s_axis_clk,
	input wire logic rst_n_cdc,
	input wire logic frame_end,
	input ext_num_t ext_num,
	input slot_mask_t match
);

	int end_fails = 0;
	int num_fails = 0;
	int match_fails = 0;

	// one frame_end pulse per frame.
	a_end_single: assert property (@(posedge s_axis_clk) disable iff (!rst_n_cdc)
		frame_end |=> !frame_end)
	else begin
		end_fails++;
		$error("frame_end high on two cycles in a row");
	end

	a_num_limit: assert property (@(posedge s_axis_clk) disable iff (!rst_n_cdc)
		ext_num <= 5'd16)
	else begin
		num_fails++;
		$error("capture count above 16");
	end

	// frame_end trails the sampled tlast by one edge, the report by two more.
	a_match_timing: assert property (@(posedge s_axis_clk) disable iff (!rst_n_cdc)
		$changed(match) |-> $past(frame_end, 2))
	else begin
		match_fails++;
		$error("match changed without a frame end two cycles before");
	end

endmodule

bind match_report frame_match_chk u_chk (
	.s_axis_clk(s_axis_clk),
	.rst_n_cdc(rst_n_cdc),
	.frame_end(res.frame_end),
	.ext_num(res.ext_num),
	.match(match)
);

`default_nettype wire

// ==== tests/frame_match_monitor.sv ====
// checks output beats against expected bytes from the driver and its own lfsr model; single clock.
`timescale 1ns/1ns
`default_nettype none

module frame_match_monitor import frame_match_pkg::*; (
	input wire logic s_axis_clk,
	input wire logic rst_n_cdc,
	input wire logic s_axis_tvalid,
	input wire logic s_axis_tuser,
	input wire logic s_axis_tlast,
	input byte_t exp_byte,
	input wire logic exp_rand,
	input int test_idx,
	input byte_t m_axis_tdata,
	input wire logic m_axis_tuser,
	input wire logic m_axis_tlast,
	input wire logic m_axis_tvalid,
	input slot_mask_t match,
	input report_id_t match_id,
	input ext_num_t match_ext_num,
	input ext_data_t match_ext_data
);

	logic [9:0] out_q [$];
	logic [9:0] head;
	byte_t model;
	int beat_errors = 0;
	int report_errors = 0;

	// taps 8, 6, 5 and 4, shifting left.
	function automatic byte_t lfsr_next(input byte_t v);
		return {v[6:0], v[7] ^ v[5] ^ v[4] ^ v[3]};
	endfunction

	function automatic int mismatch(input string name, input logic [127:0] got,
			input logic [127:0] want);
		if (got !== want) begin
			$display("[ERROR] test %0d %s: got 0x%0h expected 0x%0h", test_idx, name, got, want);
			return 1;
		end
		return 0;
	endfunction

	function automatic int error_count();
		return beat_errors + report_errors;
	endfunction

	// outputs are checked before the new input beat is queued.
	always @(posedge s_axis_clk) begin
		if (!rst_n_cdc) begin
			model = 8'd11;
			out_q.delete();
		end else begin
			if (m_axis_tvalid) begin
				if (out_q.size() == 0) begin
					$display("test %0d: output beat with no input beat", test_idx);
					beat_errors++;
				end else begin
					head = out_q.pop_front();
					beat_errors += mismatch("m_axis_tdata", m_axis_tdata, head[7:0]);
					beat_errors += mismatch("m_axis_tuser", m_axis_tuser, head[8]);
					beat_errors += mismatch("m_axis_tlast", m_axis_tlast, head[9]);
				end
			end
			if (s_axis_tvalid) begin
				model = lfsr_next(model);
				out_q.push_back({s_axis_tlast, s_axis_tuser, exp_rand ? model : exp_byte});
			end
		end
	end

	task automatic check_report(input logic rep, input slot_mask_t exp_match,
			input report_id_t exp_id, input ext_num_t exp_num, input ext_data_t exp_data,
			input int err_mark);
		report_id_t id_before;
		int waited;
		id_before = match_id;
		waited = 0;
		if (rep) begin
			while (match_id == id_before && waited < 16) begin
				@(negedge s_axis_clk);
				waited++;
			end
			if (match_id == id_before) begin
				$display("test %0d: no report within 16 cycles", test_idx);
				report_errors++;
			end
		end else begin
			// held outputs are checked well past the report slot.
			while (waited < 8) begin
				@(negedge s_axis_clk);
				waited++;
			end
		end
		report_errors += mismatch("match", match, exp_match);
		report_errors += mismatch("match_id", match_id, exp_id);
		report_errors += mismatch("match_ext_num", match_ext_num, exp_num);
		report_errors += mismatch("match_ext_data", match_ext_data, exp_data);
		waited = 0;
		while (out_q.size() != 0 && waited < 8) begin
			@(negedge s_axis_clk);
			waited++;
		end
		if (out_q.size() != 0) begin
			$display("test %0d: %0d output beats never arrived", test_idx, out_q.size());
			report_errors++;
		end
		if (error_count() == err_mark) begin
			$display("test %0d: ok", test_idx);
		end else begin
			$display("test %0d: failed with %0d errors", test_idx, error_count() - err_mark);
		end
	endtask

endmodule

`default_nettype wire

// ==== tests/frame_match_tb.sv ====
// drives a table of frames through the matcher; patterns are loaded only while the stream is idle.
`timescale 1ns/1ns
`default_nettype none

module frame_match_tb import frame_match_pkg::*; ();

	typedef struct {
		int len;
		slot_mask_t slots;
		slot_mask_t en;
		int spec_pos;
		pat_word_t spec_flags;
		pat_word_t spec_data;
		int wrong_pos;
		int cap_lo;
		int cap_hi;
		int out_kind;
		byte_t out_byte;
		logic rep;
		slot_mask_t exp_match;
		report_id_t exp_id;
		ext_num_t exp_num;
	} test_t;

	logic s_axis_clk;
	logic rst_n_cdc;
	slot_mask_t match_en;
	slot_mask_t match;
	report_id_t match_id;
	ext_num_t match_ext_num;
	ext_data_t match_ext_data;
	byte_t s_axis_tdata;
	logic s_axis_tuser;
	logic s_axis_tlast;
	logic s_axis_tvalid;
	byte_t m_axis_tdata;
	logic m_axis_tuser;
	logic m_axis_tlast;
	logic m_axis_tvalid;
	logic cfg_we;
	pat_addr_t cfg_addr;
	pat_word_t cfg_data;
	pat_word_t cfg_flags;

	test_t tests [11];
	byte_t frame [32];
	logic user_b [32];
	logic [31:0] rng_state;
	byte_t exp_byte;
	logic exp_rand;
	ext_data_t exp_data;
	byte_t r;
	int test_idx;
	int err_mark;
	int test_fails;
	int asserts;

	frame_match_top UUT (.*);

	frame_match_monitor mon (.*);

	always #2 s_axis_clk = ~s_axis_clk;

	function automatic logic [31:0] galois_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	function automatic byte_t rand_bits(input int n);
		byte_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[6:0], rng_state[0]};
			rng_state = galois_step(rng_state);
		end
		return v;
	endfunction

	// non-matching slots get a pattern byte one bit off the frame byte.
	task automatic load_patterns(input int t);
		pat_word_t d;
		pat_word_t f;
		for (int p = 0; p < tests[t].len; p++) begin
			f = '0;
			for (int i = 0; i < 4; i++) begin
				d[8*i +: 8] = tests[t].slots[i] ? frame[p] : frame[p] ^ 8'h01;
			end
			if (p == tests[t].spec_pos) begin
				f = tests[t].spec_flags;
				for (int i = 0; i < 4; i++) begin
					if (f[8*i]) begin
						d[8*i +: 8] = tests[t].spec_data[8*i +: 8];
					end
				end
			end
			if (p >= tests[t].cap_lo && p <= tests[t].cap_hi) begin
				f[28] = 1'b1;
			end
			@(posedge s_axis_clk);
			cfg_we <= 1'b1;
			cfg_addr <= pat_addr_t'(p);
			cfg_data <= d;
			cfg_flags <= f;
		end
		@(posedge s_axis_clk);
		cfg_we <= 1'b0;
	endtask

	task automatic send_frame(input int t);
		logic spec;
		for (int p = 0; p < tests[t].len; p++) begin
			spec = (p == tests[t].spec_pos);
			@(posedge s_axis_clk);
			s_axis_tdata <= frame[p];
			s_axis_tuser <= user_b[p];
			s_axis_tlast <= (p == tests[t].len - 1);
			s_axis_tvalid <= 1'b1;
			exp_byte <= (spec && tests[t].out_kind == 1) ? tests[t].out_byte : frame[p];
			exp_rand <= spec && tests[t].out_kind == 2;
		end
		@(posedge s_axis_clk);
		s_axis_tvalid <= 1'b0;
		s_axis_tlast <= 1'b0;
		exp_rand <= 1'b0;
	endtask

	initial begin
		s_axis_clk = 1'b0;
		rst_n_cdc = 1'b0;
		match_en = '0;
		s_axis_tdata = '0;
		s_axis_tuser = 1'b0;
		s_axis_tlast = 1'b0;
		s_axis_tvalid = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_data = '0;
		cfg_flags = '0;
		exp_byte = '0;
		exp_rand = 1'b0;
		test_idx = 0;
		test_fails = 0;
		rng_state = 32'h82147023;
		// len slots en spec flags data wrong cap_lo cap_hi kind byte rep match id num
		tests[0] = '{8, 4'h0, 4'hf, -1, 32'h0, 32'h0, -1, 0, -1, 0, 8'h00, 0, 4'h0, 0, 0};
		tests[1] = '{6, 4'h1, 4'hf, 2, 32'h01, 32'hc3, -1, 0, -1, 0, 8'h00, 1, 4'h1, 1, 0};
		tests[2] = '{6, 4'h1, 4'hf, 2, 32'h01, 32'hc3, -1, 0, -1, 0, 8'h00, 1, 4'h1, 2, 0};
		tests[3] = '{6, 4'h1, 4'hf, 2, 32'h01, 32'hc3, -1, 0, -1, 0, 8'h00, 1, 4'h1, 3, 0};
		tests[4] = '{6, 4'h1, 4'hf, 2, 32'h01, 32'hc3, -1, 0, -1, 0, 8'h00, 1, 4'h1, 0, 0};
		tests[5] = '{6, 4'h1, 4'hf, -1, 32'h0, 32'h0, 3, 0, -1, 0, 8'h00, 0, 4'h1, 0, 0};
		tests[6] = '{7, 4'h6, 4'h4, -1, 32'h0, 32'h0, -1, 0, -1, 0, 8'h00, 1, 4'h4, 1, 0};
		tests[7] = '{7, 4'h6, 4'h6, 1, 32'h2_0000, 32'h0, -1, 0, -1, 0, 8'h00, 1, 4'h2, 2, 0};
		tests[8] = '{8, 4'h3, 4'hf, 3, 32'h0505, 32'h5aa5, -1, 0, -1, 1, 8'ha5, 1, 4'h3, 3, 0};
		tests[9] = '{8, 4'h1, 4'hf, 4, 32'h09, 32'h0, -1, 0, -1, 2, 8'h00, 1, 4'h1, 0, 0};
		tests[10] = '{24, 4'h1, 4'hf, -1, 32'h0, 32'h0, -1, 2, 21, 0, 8'h00, 1, 4'h1, 1, 16};
		repeat (2) @(posedge s_axis_clk);
		rst_n_cdc <= 1'b1;
		for (int t = 0; t < 11; t++) begin
			test_idx = t;
			for (int p = 0; p < tests[t].len; p++) begin
				frame[p] = rand_bits(8);
				r = rand_bits(1);
				user_b[p] = r[0];
			end
			load_patterns(t);
			if (tests[t].wrong_pos >= 0) begin
				frame[tests[t].wrong_pos] = frame[tests[t].wrong_pos] ^ 8'h80;
			end
			exp_data = '0;
			for (int k = 0; k < tests[t].exp_num; k++) begin
				exp_data[8*k +: 8] = frame[tests[t].cap_lo + k];
			end
			match_en <= tests[t].en;
			err_mark = mon.error_count();
			send_frame(t);
			mon.check_report(tests[t].rep, tests[t].exp_match, tests[t].exp_id,
				tests[t].exp_num, exp_data, err_mark);
			if (mon.error_count() != err_mark) begin
				test_fails++;
			end
		end
		asserts = UUT.u_report.u_chk.end_fails + UUT.u_report.u_chk.num_fails
			+ UUT.u_report.u_chk.match_fails;
		$display("summary: 11 tests, %0d failed, %0d errors, %0d assertion failures",
			test_fails, mon.error_count(), asserts);
		if (mon.error_count() == 0 && asserts == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/frame_match_pkg.sv
logic/frame_result_if.sv
logic/byte_lfsr.sv
logic/pattern_store.sv
logic/pattern_tracker.sv
logic/match_report.sv
logic/frame_match_top.sv
tests/frame_match_chk.sv
tests/frame_match_monitor.sv
tests/frame_match_tb.sv

// ==== Makefile ====
# Verilator build and run for the frame matcher testbench.
VERILATOR ?= verilator
TOP ?= frame_match_tb
RTL_TOP ?= frame_match_top
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
FAIL_MSG ?= FAIL: see errors above

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $$(grep '^logic/' $(FLIST)) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
